//--- vlog.f
rtl/rom_map_pkg.sv
rtl/rom_slot_pkg.sv
rtl/rom_region_cfg.sv
rtl/rom_slot_seq.sv
rtl/rom_ctrl_top.sv
dv/rom_ctrl_tb.sv

//--- Makefile
# Verilator build and run of the ROM controller testbench

VERILATOR ?= verilator
TOP       ?= rom_ctrl_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS    := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q '^\*\* PASS \*\*$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/rom_ctrl_tb.sv
//********************************************************************
// rom controller testbench
// runs the read round against an SDRAM model whose word is a fixed
// function of the address, checks reset, download parking, refresh
// spacing and the data handed to every consumer, incl. offset writes
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module rom_ctrl_tb;
    import rom_map_pkg::*;

    typedef struct {
        logic [main_aw-1:0]  main_a;
        logic [snd_aw-1:0]   snd_a;
        logic [char_aw-1:0]  char_a;
        logic [obj_aw-1:0]   obj_a;
        logic [scr_aw-1:0]   scr_a;
        logic                wr_en;     // offset write before the row
        region_e             wr_sel;
        logic [sdram_aw-1:0] wr_data;
        logic [7:0]          exp_main;
        logic [7:0]          exp_snd;
        logic [15:0]         exp_char;
        logic [15:0]         exp_obj;
        logic [23:0]         exp_scr;
    } stim_row_t;

    logic                clk;
    logic                loop_rst;
    logic                cen12 = 1'b0;
    logic [2:0]          H = 3'd0;
    logic [1:0]          cen_div = 2'd0;
    logic                downloading;
    logic [main_aw-1:0]  main_addr;
    logic [snd_aw-1:0]   snd_addr;
    logic [char_aw-1:0]  char_addr;
    logic [obj_aw-1:0]   obj_addr;
    logic [scr_aw-1:0]   scr_addr;
    logic [15:0]         data_read;
    logic                cfg_we;
    region_e             cfg_sel;
    logic [sdram_aw-1:0] cfg_data;
    logic [7:0]          main_dout, snd_dout;
    logic [15:0]         char_dout, obj_dout;
    logic [23:0]         scr_dout;
    logic                ready, autorefresh;
    logic [sdram_aw-1:0] sdram_addr;
    logic [sdram_aw-1:0] model_addr = '0;    // SDRAM model address register
    stim_row_t           rows [6];
    int                  value_errs;
    int                  timeouts;

    rom_ctrl_top uut (
        .clk(clk), .loop_rst(loop_rst), .cen12(cen12), .downloading(downloading), .H(H),
        .main_addr(main_addr), .snd_addr(snd_addr), .char_addr(char_addr),
        .obj_addr(obj_addr), .scr_addr(scr_addr), .data_read(data_read),
        .cfg_we(cfg_we), .cfg_sel(cfg_sel), .cfg_data(cfg_data),
        .main_dout(main_dout), .snd_dout(snd_dout), .char_dout(char_dout),
        .obj_dout(obj_dout), .scr_dout(scr_dout), .ready(ready),
        .autorefresh(autorefresh), .sdram_addr(sdram_addr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // cen12 on every third clock, H steps once per tick
    always @(negedge clk) begin
        if (cen12) H <= H + 3'd1;
        cen_div <= (cen_div == 2'd2) ? 2'd0 : cen_div + 2'd1;
        cen12   <= (cen_div == 2'd2);
    end

    function automatic logic [15:0] model_word(input logic [sdram_aw-1:0] a);
        return a[15:0] ^ 16'hA5C3;      // what the SDRAM holds at a
    endfunction

    always @(posedge clk) model_addr <= sdram_addr;    // word valid one clock later
    assign data_read = model_word(model_addr);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] pick_byte(input logic [15:0] w, input logic lsb);
        return lsb ? w[7:0] : w[15:8];  // even byte address is the upper half
    endfunction

    // random addresses, LSBs alternate per row; rows 2 and 4 move char and obj
    task automatic fill_table();
        logic [31:0]         rnd;
        logic [sdram_aw-1:0] snd_o, char_o, scr_o, scr2_o, obj_o, scr_w;
        logic [15:0]         hi;
        rnd    = 32'h6abd;
        snd_o  = 22'h0A000;
        char_o = 22'h0E000;
        scr_o  = 22'h10000;
        scr2_o = 22'h08000;
        obj_o  = 22'h20000;
        for (int i = 0; i < 6; i++) begin
            rnd = xorshift(rnd);
            rows[i].main_a = rnd[16:0];
            rows[i].main_a[0] = i[0];
            rnd = xorshift(rnd);
            rows[i].snd_a = rnd[14:0];
            rows[i].snd_a[0] = ~i[0];
            rnd = xorshift(rnd);
            rows[i].char_a = rnd[12:0];
            rnd = xorshift(rnd);
            rows[i].obj_a = rnd[15:0];
            rnd = xorshift(rnd);
            rows[i].scr_a = rnd[14:0];
            rows[i].wr_en   = (i == 2) || (i == 4);
            rows[i].wr_sel  = (i == 4) ? region_obj : ((i == 2) ? region_char : region_snd);
            rows[i].wr_data = (i == 2) ? 22'h30000 : 22'h01800;
            if (i == 2) char_o = rows[i].wr_data;
            if (i == 4) obj_o = rows[i].wr_data;
            rows[i].exp_main = pick_byte(model_word(sdram_aw'(rows[i].main_a[main_aw-1:1])),
                                         rows[i].main_a[0]);
            rows[i].exp_snd  = pick_byte(model_word(snd_o + sdram_aw'(rows[i].snd_a[snd_aw-1:1])),
                                         rows[i].snd_a[0]);
            rows[i].exp_char = model_word(char_o + sdram_aw'(rows[i].char_a));
            rows[i].exp_obj  = model_word(obj_o + sdram_aw'(rows[i].obj_a));
            scr_w = scr_o + sdram_aw'(rows[i].scr_a);
            hi    = model_word(scr_w + scr2_o);     // upper plane, halves merged
            rows[i].exp_scr = {hi[15:8] | hi[7:0], model_word(scr_w)};
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            value_errs++;
            $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // returns on the falling edge right after the next cen12 clock
    task automatic wait_tick();
        int guard;
        guard = 0;
        do begin
            @(posedge clk);
            guard++;
        end while (!cen12 && guard < 8);
        if (!cen12) begin
            timeouts++;
            $display("timeout at %0t ns: no cen12 strobe within 8 clocks", $time);
        end
        @(negedge clk);
    endtask

    task automatic write_offset(input region_e sel, input logic [sdram_aw-1:0] data);
        cfg_sel  = sel;
        cfg_data = data;
        cfg_we   = 1'b1;
        @(negedge clk);                 // single clock strobe
        cfg_we   = 1'b0;
    endtask

    initial begin
        int guard;
        int ref_cnt;
        int last_ref;
        loop_rst    = 1'b1;
        downloading = 1'b1;             // board comes up in download
        main_addr   = '0;
        snd_addr    = '0;
        char_addr   = '0;
        obj_addr    = '0;
        scr_addr    = '0;
        cfg_we      = 1'b0;
        cfg_sel     = region_snd;
        cfg_data    = '0;
        value_errs  = 0;
        timeouts    = 0;
        ref_cnt     = 0;
        last_ref    = -1;
        fill_table();
        repeat (4) @(posedge clk);      // four reset clocks
        @(negedge clk);
        loop_rst = 1'b0;
        check_val("ready", 32'(ready), 32'd0);
        check_val("autorefresh", 32'(autorefresh), 32'd0);
        check_val("sdram_addr", 32'(sdram_addr), 32'd0);
        check_val("main_dout", 32'(main_dout), 32'd0);
        check_val("snd_dout", 32'(snd_dout), 32'd0);
        check_val("char_dout", 32'(char_dout), 32'd0);
        check_val("obj_dout", 32'(obj_dout), 32'd0);
        check_val("scr_dout", 32'(scr_dout), 32'd0);
        for (int n = 0; n < 40; n++) begin
            wait_tick();
            check_val("ready", 32'(ready), 32'd0);              // parked round
            check_val("autorefresh", 32'(autorefresh), 32'd0);
        end
        downloading = 1'b0;
        wait_tick();                    // first tick of the running round
        guard = 0;
        while (ready !== 1'b1 && guard < 2) begin
            @(negedge clk);
            guard++;
        end
        if (ready !== 1'b1) begin
            timeouts++;
            $display("timeout at %0t ns: ready not high two clocks after first tick", $time);
        end
        for (int n = 0; n < 64; n++) begin
            wait_tick();
            check_val("ready", 32'(ready), 32'd1);
            if (autorefresh) begin
                if (last_ref >= 0) check_val("autorefresh spacing", 32'(n - last_ref), 32'd16);
                last_ref = n;
                ref_cnt++;
            end
        end
        check_val("autorefresh count", 32'(ref_cnt), 32'd4);
        for (int i = 0; i < 6; i++) begin
            main_addr = rows[i].main_a;
            snd_addr  = rows[i].snd_a;
            char_addr = rows[i].char_a;
            obj_addr  = rows[i].obj_a;
            scr_addr  = rows[i].scr_a;
            if (rows[i].wr_en) write_offset(rows[i].wr_sel, rows[i].wr_data);
            for (int n = 0; n < 32; n++) wait_tick();          // two full rounds
            check_val("main_dout", 32'(main_dout), 32'(rows[i].exp_main));
            check_val("snd_dout", 32'(snd_dout), 32'(rows[i].exp_snd));
            check_val("char_dout", 32'(char_dout), 32'(rows[i].exp_char));
            check_val("obj_dout", 32'(obj_dout), 32'(rows[i].exp_obj));
            check_val("scr_dout", 32'(scr_dout), 32'(rows[i].exp_scr));
        end
        $display("summary: %0d value errors, %0d timeouts", value_errs, timeouts);
        if (value_errs == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/rom_ctrl_top.sv
//********************************************************************
// rom controller top
// joins the region offset registers with the read slot sequencer
// offsets flow from the config block straight into the sequencer
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module rom_ctrl_top (
    input  logic                                clk,
    input  logic                                loop_rst,
    input  logic                                cen12,
    input  logic                                downloading,
    input  logic [2:0]                          H,
    input  logic [rom_map_pkg::main_aw-1:0]     main_addr,
    input  logic [rom_map_pkg::snd_aw-1:0]      snd_addr,
    input  logic [rom_map_pkg::char_aw-1:0]     char_addr,
    input  logic [rom_map_pkg::obj_aw-1:0]      obj_addr,
    input  logic [rom_map_pkg::scr_aw-1:0]      scr_addr,
    input  logic [15:0]                         data_read,
    input  logic                                cfg_we,      // offset write
    input  rom_map_pkg::region_e                cfg_sel,
    input  logic [rom_map_pkg::sdram_aw-1:0]    cfg_data,
    output logic [rom_slot_pkg::byte_dw-1:0]    main_dout,
    output logic [rom_slot_pkg::byte_dw-1:0]    snd_dout,
    output logic [rom_slot_pkg::char_dw-1:0]    char_dout,
    output logic [rom_slot_pkg::obj_dw-1:0]     obj_dout,
    output logic [rom_slot_pkg::scr_dw-1:0]     scr_dout,
    output logic                                ready,
    output logic                                autorefresh,
    output logic [rom_map_pkg::sdram_aw-1:0]    sdram_addr
);
    import rom_map_pkg::*;

    // region bases, config block to sequencer
    logic [sdram_aw-1:0] snd_off;
    logic [sdram_aw-1:0] char_off;
    logic [sdram_aw-1:0] scr_off;
    logic [sdram_aw-1:0] scr2_off;
    logic [sdram_aw-1:0] obj_off;

    rom_region_cfg u_cfg (
        .clk      (clk),
        .loop_rst (loop_rst),
        .cfg_we   (cfg_we),
        .cfg_sel  (cfg_sel),
        .cfg_data (cfg_data),
        .snd_off  (snd_off),
        .char_off (char_off),
        .scr_off  (scr_off),
        .scr2_off (scr2_off),
        .obj_off  (obj_off)
    );

    rom_slot_seq u_seq (
        .clk         (clk),
        .loop_rst    (loop_rst),
        .cen12       (cen12),
        .downloading (downloading),
        .H           (H),
        .main_addr   (main_addr),
        .snd_addr    (snd_addr),
        .char_addr   (char_addr),
        .obj_addr    (obj_addr),
        .scr_addr    (scr_addr),
        .snd_off     (snd_off),
        .char_off    (char_off),
        .scr_off     (scr_off),
        .scr2_off    (scr2_off),
        .obj_off     (obj_off),
        .data_read   (data_read),
        .main_dout   (main_dout),
        .snd_dout    (snd_dout),
        .char_dout   (char_dout),
        .obj_dout    (obj_dout),
        .scr_dout    (scr_dout),
        .ready       (ready),
        .autorefresh (autorefresh),
        .sdram_addr  (sdram_addr)
    );

endmodule

`default_nettype wire

//--- rtl/rom_slot_seq.sv
//********************************************************************
// rom read slot sequencer
// runs a fixed 16 slot round on cen12, issuing one SDRAM word
// address per slot and storing the word that comes back into the
// consumer that owns the slot. slot 14 asks for an autorefresh.
// while ROMs download the round is parked and aligned to H
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module rom_slot_seq (
    input  logic                                clk,
    input  logic                                loop_rst,
    input  logic                                cen12,       // 12 MHz enable
    input  logic                                downloading,
    input  logic [2:0]                          H,           // pixel counter
    // consumer addresses
    input  logic [rom_map_pkg::main_aw-1:0]     main_addr,
    input  logic [rom_map_pkg::snd_aw-1:0]      snd_addr,
    input  logic [rom_map_pkg::char_aw-1:0]     char_addr,
    input  logic [rom_map_pkg::obj_aw-1:0]      obj_addr,
    input  logic [rom_map_pkg::scr_aw-1:0]      scr_addr,
    // region bases from the config block
    input  logic [rom_map_pkg::sdram_aw-1:0]    snd_off,
    input  logic [rom_map_pkg::sdram_aw-1:0]    char_off,
    input  logic [rom_map_pkg::sdram_aw-1:0]    scr_off,
    input  logic [rom_map_pkg::sdram_aw-1:0]    scr2_off,
    input  logic [rom_map_pkg::sdram_aw-1:0]    obj_off,
    input  logic [15:0]                         data_read,   // SDRAM word
    // consumer data
    output logic [rom_slot_pkg::byte_dw-1:0]    main_dout,
    output logic [rom_slot_pkg::byte_dw-1:0]    snd_dout,
    output logic [rom_slot_pkg::char_dw-1:0]    char_dout,
    output logic [rom_slot_pkg::obj_dw-1:0]     obj_dout,
    output logic [rom_slot_pkg::scr_dw-1:0]     scr_dout,
    output logic                                ready,
    output logic                                autorefresh,
    output logic [rom_map_pkg::sdram_aw-1:0]    sdram_addr
);
    import rom_map_pkg::*;
    import rom_slot_pkg::*;

    localparam int slot_w = $clog2(round_len);

    slot_e       slot;              // slot issued on the next tick
    slot_e       prev_slot;         // slot whose word is on data_read
    logic [2:0]  last_h;            // H seen on the previous tick
    logic        h_same;
    logic        snd_lsb;           // byte select kept from issue time
    logic        main_lsb;
    logic        pre_ready;         // set once the round has started
    logic [15:0] scr_aux;           // lower tile word waits for the upper

    // H history only steers the parked round, no reset needed
    always_ff @(posedge clk) begin
        if (cen12) begin
            last_h <= H;
        end
    end

    always_comb begin
        h_same    = (last_h == H);
        prev_slot = slot_e'(slot - slot_w'(1));    // wraps 0 -> 15
    end

    always_ff @(posedge clk) begin
        if (loop_rst) begin
            slot        <= slot_snd0;
            snd_lsb     <= 1'b0;
            main_lsb    <= 1'b0;
            pre_ready   <= 1'b0;
            scr_aux     <= '0;
            autorefresh <= 1'b0;
            sdram_addr  <= '0;
            main_dout   <= '0;
            snd_dout    <= '0;
            char_dout   <= '0;
            obj_dout    <= '0;
            scr_dout    <= '0;
        end else begin
            if (downloading) begin
                autorefresh <= 1'b0;                // no refresh requests during download
            end
            if (cen12) begin
                if (downloading) begin
                    // park the round in step with the pixel phase
                    // so reads start at a known H once download ends
                    slot <= h_same ? slot_e'({H, 1'b1}) : slot_e'({H + 3'd1, 1'b0});
                end else begin
                    pre_ready   <= 1'b1;
                    slot        <= slot_e'(slot + slot_w'(1));
                    autorefresh <= (slot == refresh_slot);  // one tick per round

                    // store the word asked for on the previous tick
                    // nothing was issued yet on the very first tick
                    if (pre_ready) begin
                        case (prev_slot)
                            slot_snd0, slot_snd1, slot_snd2, slot_snd3: begin
                                snd_dout <= snd_lsb ? data_read[7:0] : data_read[15:8];
                            end
                            slot_main0, slot_main1, slot_main2, slot_main3: begin
                                main_dout <= main_lsb ? data_read[7:0] : data_read[15:8];
                            end
                            slot_char: begin
                                char_dout <= data_read;
                            end
                            slot_obj0, slot_obj1: begin
                                obj_dout <= data_read;
                            end
                            slot_scr_lo: begin
                                scr_aux <= data_read;       // z and y planes
                            end
                            slot_scr_hi: begin
                                // x plane uses one half of the word, the other is zero
                                scr_dout <= {data_read[15:8] | data_read[7:0], scr_aux};
                            end
                            default: begin
                            end
                        endcase
                    end

                    // issue the address of the current slot
                    case (slot)
                        slot_snd0, slot_snd1, slot_snd2, slot_snd3: begin
                            sdram_addr <= snd_off + sdram_aw'(snd_addr[snd_aw-1:1]);
                            snd_lsb    <= snd_addr[0];
                        end
                        slot_main0, slot_main1, slot_main2, slot_main3: begin
                            sdram_addr <= sdram_aw'(main_addr[main_aw-1:1]); // main at 0
                            main_lsb   <= main_addr[0];
                        end
                        slot_char: begin
                            sdram_addr <= char_off + sdram_aw'(char_addr);
                        end
                        slot_obj0, slot_obj1: begin
                            sdram_addr <= obj_off + sdram_aw'(obj_addr);
                        end
                        slot_scr_lo: begin
                            sdram_addr <= scr_off + sdram_aw'(scr_addr);
                        end
                        slot_scr_hi: begin
                            sdram_addr <= sdram_addr + scr2_off; // same tile, other plane
                        end
                        default: begin
                            // idle and refresh slots keep the last address
                        end
                    endcase
                end
            end
        end
    end

    // ready trails the internal flag by one clock
    always_ff @(posedge clk) begin
        if (loop_rst) begin
            ready <= 1'b0;
        end else begin
            ready <= pre_ready;
        end
    end

    // the SDRAM controller must not see a refresh request during download
    a_no_refresh_in_dl: assert property (
        @(posedge clk) disable iff (loop_rst)
        downloading |-> !autorefresh
    ) else $error("autorefresh high while downloading");

    // the SDRAM side only samples on cen12, the address must hold in between
    a_addr_stable: assert property (
        @(posedge clk) disable iff (loop_rst)
        !cen12 |=> $stable(sdram_addr)
    ) else $error("sdram_addr changed without cen12");

endmodule

`default_nettype wire

//--- rtl/rom_region_cfg.sv
//********************************************************************
// rom region offset registers
// holds the SDRAM base of each ROM region used by the scheduler
// loads the original board map on reset, any register can be
// rewritten through a single write strobe
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module rom_region_cfg (
    input  logic                             clk,
    input  logic                             loop_rst,
    input  logic                             cfg_we,       // write strobe
    input  rom_map_pkg::region_e             cfg_sel,      // which offset
    input  logic [rom_map_pkg::sdram_aw-1:0] cfg_data,
    output logic [rom_map_pkg::sdram_aw-1:0] snd_off,
    output logic [rom_map_pkg::sdram_aw-1:0] char_off,
    output logic [rom_map_pkg::sdram_aw-1:0] scr_off,
    output logic [rom_map_pkg::sdram_aw-1:0] scr2_off,
    output logic [rom_map_pkg::sdram_aw-1:0] obj_off
);
    import rom_map_pkg::*;

    // one register per region
    // a write lands on the strobe clock and is seen by the sequencer
    // from the next clock on
    always_ff @(posedge clk) begin
        if (loop_rst) begin
            snd_off  <= def_snd_off;             // back to the original map
            char_off <= def_char_off;
            scr_off  <= def_scr_off;
            scr2_off <= def_scr2_off;
            obj_off  <= def_obj_off;
        end else if (cfg_we) begin
            case (cfg_sel)
                region_snd: begin
                    snd_off <= cfg_data;
                end
                region_char: begin
                    char_off <= cfg_data;
                end
                region_scr: begin
                    scr_off <= cfg_data;
                end
                region_scr2: begin
                    scr2_off <= cfg_data;        // upper byte plane of tiles
                end
                region_obj: begin
                    obj_off <= cfg_data;
                end
                default: begin
                    // unmapped selector, nothing changes
                end
            endcase
        end
    end

    // a write must always target one of the five regions
    // an out of range selector would silently drop the new map entry
    a_cfg_sel_legal: assert property (
        @(posedge clk) disable iff (loop_rst)
        cfg_we |-> cfg_sel inside {region_snd, region_char, region_scr,
                                   region_scr2, region_obj}
    ) else $error("cfg write with illegal region selector %0d", cfg_sel);

endmodule

`default_nettype wire

//--- rtl/rom_slot_pkg.sv
//********************************************************************
// rom read round definitions
// names the sixteen slots of the fixed SDRAM read round, marks the
// refresh slot and gives the data widths handed to each consumer
//********************************************************************
`default_nettype none

package rom_slot_pkg;

    localparam int round_len = 16;      // slots per round, one per cen12

    // slot order is fixed, sound and main share every group of four
    typedef enum logic [3:0] {
        slot_snd0    = 4'd0,
        slot_main0   = 4'd1,
        slot_char    = 4'd2,
        slot_obj0    = 4'd3,
        slot_snd1    = 4'd4,
        slot_main1   = 4'd5,
        slot_scr_lo  = 4'd6,            // scroll tile, lower word
        slot_scr_hi  = 4'd7,            // scroll tile, upper byte plane
        slot_snd2    = 4'd8,
        slot_main2   = 4'd9,
        slot_idle0   = 4'd10,
        slot_obj1    = 4'd11,
        slot_snd3    = 4'd12,
        slot_main3   = 4'd13,
        slot_refresh = 4'd14,
        slot_idle1   = 4'd15
    } slot_e;

    localparam slot_e refresh_slot = slot_refresh;

    // consumer data widths
    localparam int char_dw = 16;
    localparam int obj_dw  = 16;
    localparam int scr_dw  = 24;        // two words merged into one tile
    localparam int byte_dw = 8;         // sound and main cpu

endpackage

`default_nettype wire

//--- rtl/rom_map_pkg.sv
//********************************************************************
// rom memory map definitions
// shared SDRAM address width, the offset register selector and the
// reset map of the original board, plus the address widths seen on
// each consumer side of the ROM scheduler
//********************************************************************
`default_nettype none

package rom_map_pkg;

    localparam int sdram_aw = 22;       // SDRAM word address

    // selects one offset register in the config block
    typedef enum logic [2:0] {
        region_snd  = 3'd0,
        region_char = 3'd1,
        region_scr  = 3'd2,
        region_scr2 = 3'd3,             // upper byte plane of the scroll tiles
        region_obj  = 3'd4
    } region_e;

    // original game layout, word addresses
    localparam logic [sdram_aw-1:0] def_snd_off  = 22'h0A000;
    localparam logic [sdram_aw-1:0] def_char_off = 22'h0E000;
    localparam logic [sdram_aw-1:0] def_scr_off  = 22'h10000;
    localparam logic [sdram_aw-1:0] def_scr2_off = 22'h08000;
    localparam logic [sdram_aw-1:0] def_obj_off  = 22'h20000;

    // consumer address widths
    localparam int main_aw = 17;        // byte address, main cpu at word 0
    localparam int snd_aw  = 15;        // byte address
    localparam int char_aw = 13;        // word address
    localparam int obj_aw  = 16;
    localparam int scr_aw  = 15;

endpackage

`default_nettype wire
